//--- tb.f
hdl/ts_pkg.sv
hdl/ts_bus_regs.sv
hdl/ts_capture.sv
hdl/ts_fifo.sv
hdl/ts_word_packer.sv
hdl/timestamp_core.sv
testbench/tb_timestamp_core.sv

//--- Makefile
TOP = tb_timestamp_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f
	verilator --lint-only --top-module timestamp_core hdl/ts_pkg.sv hdl/ts_bus_regs.sv \
		hdl/ts_capture.sv hdl/ts_fifo.sv hdl/ts_word_packer.sv hdl/timestamp_core.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f tb.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_timestamp_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_timestamp_core;
    import ts_pkg::*;

    localparam int ABUSWIDTH = 16;
    localparam logic [3:0] IDENTIFIER = 4'b0001;
    localparam int EVT_DEPTH = 4;
    localparam int OUT_DEPTH = 16;
    localparam int TIMEOUT_CYCLES = 4000;

    logic BUS_CLK;
    logic RST_SYNC;
    logic [ABUSWIDTH-1:0] bus_add;
    logic [7:0] bus_data_in;
    logic bus_wr;
    logic bus_rd;
    logic [7:0] bus_data_out;
    logic di;
    logic fifo_read;
    logic fifo_empty;
    ts_word_t fifo_data;

    int errors = 0;
    int run_cycles = 0;
    integer seed = 32'h0fc2bd46;

    // reference model state, updated at every clock edge
    logic [63:0] cycle_cnt;
    logic en_m;
    logic di_m;
    logic strobe;
    logic pop;
    logic wr_o;
    logic rd_o;
    int evt_occ;
    int pk_left;
    int out_occ;
    logic [7:0] lost_m;
    logic [63:0] exp_q[$];

    timestamp_core #(
        .ABUSWIDTH(ABUSWIDTH),
        .IDENTIFIER(IDENTIFIER),
        .EVT_DEPTH(EVT_DEPTH),
        .OUT_DEPTH(OUT_DEPTH)
    ) i_dut (
        .BUS_CLK(BUS_CLK),
        .RST_SYNC(RST_SYNC),
        .bus_add(bus_add),
        .bus_data_in(bus_data_in),
        .bus_wr(bus_wr),
        .bus_rd(bus_rd),
        .bus_data_out(bus_data_out),
        .di(di),
        .fifo_read(fifo_read),
        .fifo_empty(fifo_empty),
        .fifo_data(fifo_data)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #2 BUS_CLK = ~BUS_CLK;
    end

    // the model tracks the counter, the event buffer occupancy, the words left in the
    // packer and the output FIFO occupancy from the values sampled at each edge
    always @(posedge BUS_CLK) begin
        if (RST_SYNC || (bus_wr && bus_add == ABUSWIDTH'(REG_VERSION))) begin
            cycle_cnt = '0;
            en_m = 1'b0;
            di_m = 1'b0;
            evt_occ = 0;
            pk_left = 0;
            out_occ = 0;
            lost_m = '0;
            exp_q.delete();
        end else begin
            strobe = en_m && di && !di_m;
            pop = (pk_left == 0) && (evt_occ != 0);
            wr_o = (pk_left != 0) && (out_occ < OUT_DEPTH);
            rd_o = fifo_read && (out_occ != 0);
            if (strobe && evt_occ < EVT_DEPTH) begin
                exp_q.push_back(cycle_cnt);
                evt_occ++;
            end else if (strobe && lost_m != 8'hff) begin
                lost_m++;
            end
            if (pop) begin
                evt_occ--;
                pk_left = 3;
            end else if (wr_o) begin
                pk_left--;
            end
            out_occ = out_occ + int'(wr_o) - int'(rd_o);
            if (bus_wr && bus_add == ABUSWIDTH'(REG_ENABLE)) begin
                en_m = bus_data_in[0];
            end
            di_m = di;
            cycle_cnt++;
        end
    end

    always @(posedge BUS_CLK) begin
        run_cycles++;
        if (run_cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic step_cycle();
        @(posedge BUS_CLK);
        #1;
    endtask

    task automatic bus_write(input int addr, input logic [7:0] data);
        step_cycle();
        bus_add = ABUSWIDTH'(addr);
        bus_data_in = data;
        bus_wr = 1'b1;
        step_cycle();
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input int addr, output logic [7:0] data);
        step_cycle();
        bus_add = ABUSWIDTH'(addr);
        bus_rd = 1'b1;
        step_cycle();
        bus_rd = 1'b0;
        data = bus_data_out;
    endtask

    // di is high for one cycle and then low for gap cycles
    task automatic pulse_di(input int gap);
        step_cycle();
        di = 1'b1;
        step_cycle();
        di = 1'b0;
        repeat (gap) step_cycle();
    endtask

    task automatic pop_word(output ts_word_t w);
        while (fifo_empty) step_cycle();
        w = fifo_data;
        fifo_read = 1'b1;
        step_cycle();
        fifo_read = 1'b0;
    endtask

    task automatic check_word(input string name, input ts_word_t exp, input ts_word_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    function automatic ts_word_t make_word(input logic [63:0] stamp, input ts_tag_e tag);
        ts_word_t w;
        w.id = IDENTIFIER;
        w.tag = tag;
        case (tag)
            TAG_MID: w.payload = stamp[47:24];
            TAG_HIGH: w.payload = {8'h00, stamp[63:48]};
            default: w.payload = stamp[23:0];
        endcase
        return w;
    endfunction

    // reads the three words of the oldest expected stamp
    task automatic check_stamp_words(input string name);
        ts_word_t w;
        logic [63:0] stamp;
        pop_word(w);
        if (exp_q.size() == 0) begin
            errors++;
            $display("%s: the DUT sent a word while no event was expected", name);
            return;
        end
        stamp = exp_q.pop_front();
        check_word({name, " low"}, make_word(stamp, TAG_LOW), w);
        pop_word(w);
        check_word({name, " mid"}, make_word(stamp, TAG_MID), w);
        pop_word(w);
        check_word({name, " high"}, make_word(stamp, TAG_HIGH), w);
    endtask

    task automatic test_reset_regs();
        logic [7:0] rd;
        bus_read(REG_VERSION, rd);
        check_byte("reset version", VERSION, rd);
        bus_read(REG_ENABLE, rd);
        check_byte("reset enable", 8'd0, rd);
        bus_read(REG_LOST, rd);
        check_byte("reset lost", 8'd0, rd);
        check_flag("reset fifo_empty", 1'b1, fifo_empty);
        bus_write(REG_ENABLE, 8'd1);
        bus_read(REG_ENABLE, rd);
        check_byte("enable readback", 8'd1, rd);
    endtask

    task automatic test_single_stamp();
        pulse_di(5);
        check_stamp_words("single stamp");
        repeat (10) step_cycle();
        check_flag("single stamp word count", 1'b1, fifo_empty);
    endtask

    task automatic test_disabled();
        bus_write(REG_ENABLE, 8'd0);
        pulse_di(3);
        pulse_di(3);
        pulse_di(3);
        repeat (20) begin
            step_cycle();
            check_flag("disabled fifo_empty", 1'b1, fifo_empty);
        end
    endtask

    // more pulses than the output FIFO and the event buffer can hold, so the last ones are lost
    task automatic test_burst();
        logic [7:0] rd;
        int n;
        bus_write(REG_ENABLE, 8'd1);
        repeat (12) pulse_di(1 + ($unsigned($random(seed)) % 4));
        repeat (40) step_cycle();
        n = exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_stamp_words("burst");
        end
        bus_read(REG_LOST, rd);
        check_byte("burst lost", lost_m, rd);
        repeat (10) step_cycle();
        check_flag("burst drained", 1'b1, fifo_empty);
    endtask

    task automatic test_soft_reset();
        logic [7:0] rd;
        pulse_di(2);
        pulse_di(2);
        repeat (10) step_cycle();
        check_flag("words before soft reset", 1'b0, fifo_empty);
        bus_write(REG_VERSION, 8'd0);
        bus_read(REG_ENABLE, rd);
        check_byte("soft reset enable", 8'd0, rd);
        bus_read(REG_LOST, rd);
        check_byte("soft reset lost", 8'd0, rd);
        check_flag("soft reset fifo_empty", 1'b1, fifo_empty);
        bus_write(REG_ENABLE, 8'd1);
        pulse_di(4);
        check_stamp_words("after soft reset");
    endtask

    initial begin
        RST_SYNC = 1'b1;
        bus_add = '0;
        bus_data_in = '0;
        bus_wr = 1'b0;
        bus_rd = 1'b0;
        di = 1'b0;
        fifo_read = 1'b0;
        repeat (10) @(posedge BUS_CLK);
        #1;
        RST_SYNC = 1'b0;
        test_reset_regs();
        test_single_stamp();
        test_disabled();
        test_burst();
        test_soft_reset();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/timestamp_core.sv
`timescale 1ns/1ps
`default_nettype none

module timestamp_core #(
    parameter int ABUSWIDTH = 16,
    parameter logic [3:0] IDENTIFIER = 4'b0001,
    parameter int EVT_DEPTH = 4,
    parameter int OUT_DEPTH = 16
) (
    input  wire                 BUS_CLK,
    input  wire                 RST_SYNC,
    input  wire [ABUSWIDTH-1:0] bus_add,
    input  wire [7:0]           bus_data_in,
    input  wire                 bus_wr,
    input  wire                 bus_rd,
    output logic [7:0]          bus_data_out,
    input  wire                 di,
    input  wire                 fifo_read,
    output logic                fifo_empty,
    output ts_pkg::ts_word_t    fifo_data
);
    import ts_pkg::*;

    logic core_rst;
    logic enable;
    ts_event_t evt;
    logic evt_full;
    logic evt_empty;
    logic evt_pop;
    logic [63:0] evt_head;
    logic out_full;
    logic out_wr;
    ts_word_t out_word;

    ts_bus_regs #(
        .ABUSWIDTH(ABUSWIDTH)
    ) i_bus_regs (
        .BUS_CLK(BUS_CLK),
        .RST_SYNC(RST_SYNC),
        .bus_add(bus_add),
        .bus_data_in(bus_data_in),
        .bus_wr(bus_wr),
        .bus_rd(bus_rd),
        .evt_valid(evt.valid),
        .evt_full(evt_full),
        .bus_data_out(bus_data_out),
        .enable(enable),
        .core_rst(core_rst)
    );

    ts_capture i_capture (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .di(di),
        .enable(enable),
        .evt(evt)
    );

    // event buffer, events that arrive while it is full are dropped
    ts_fifo #(
        .WIDTH(64),
        .DEPTH(EVT_DEPTH)
    ) i_evt_fifo (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .wr(evt.valid),
        .wdata(evt.stamp),
        .rd(evt_pop),
        .rdata(evt_head),
        .empty(evt_empty),
        .full(evt_full)
    );

    ts_word_packer #(
        .IDENTIFIER(IDENTIFIER)
    ) i_word_packer (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .evt_empty(evt_empty),
        .evt_stamp(evt_head),
        .out_full(out_full),
        .evt_pop(evt_pop),
        .out_wr(out_wr),
        .out_word(out_word)
    );

    // host side, drained by fifo_read
    ts_fifo #(
        .WIDTH(32),
        .DEPTH(OUT_DEPTH)
    ) i_out_fifo (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .wr(out_wr),
        .wdata(out_word),
        .rd(fifo_read),
        .rdata(fifo_data),
        .empty(fifo_empty),
        .full(out_full)
    );

endmodule

`default_nettype wire

//--- hdl/ts_word_packer.sv
`timescale 1ns/1ps
`default_nettype none

module ts_word_packer #(
    parameter logic [3:0] IDENTIFIER = 4'b0001
) (
    input  wire              BUS_CLK,
    input  wire              core_rst,
    input  wire              evt_empty,
    input  wire [63:0]       evt_stamp,
    input  wire              out_full,
    output logic             evt_pop,
    output logic             out_wr,
    output ts_pkg::ts_word_t out_word
);
    import ts_pkg::*;

    ts_pack_state_e state;
    ts_pack_state_e state_next;
    logic [63:0] stamp_q;

    // the head is taken on the edge that leaves IDLE
    assign evt_pop = (state == IDLE) && !evt_empty;
    assign out_wr = (state != IDLE) && !out_full;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (!evt_empty) begin
                    state_next = SEND_LOW;
                end
            end
            // a full output FIFO holds each SEND state
            SEND_LOW: begin
                if (!out_full) begin
                    state_next = SEND_MID;
                end
            end
            SEND_MID: begin
                if (!out_full) begin
                    state_next = SEND_HIGH;
                end
            end
            SEND_HIGH: begin
                if (!out_full) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            stamp_q <= '0;
        end else if (evt_pop) begin
            stamp_q <= evt_stamp;
        end
    end

    // word slices follow the tag, the high word pads 16 stamp bits with zeros
    always_comb begin
        out_word.id = IDENTIFIER;
        case (state)
            SEND_MID: begin
                out_word.tag = TAG_MID;
                out_word.payload = stamp_q[47:24];
            end
            SEND_HIGH: begin
                out_word.tag = TAG_HIGH;
                out_word.payload = {8'h00, stamp_q[63:48]};
            end
            default: begin
                out_word.tag = TAG_LOW;
                out_word.payload = stamp_q[23:0];
            end
        endcase
    end

    a_no_write_when_full: assert property (
        @(posedge BUS_CLK) disable iff (core_rst) out_wr |-> !out_full
    ) else $error("packer wrote into a full output fifo");

endmodule

`default_nettype wire

//--- hdl/ts_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ts_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  wire              BUS_CLK,
    input  wire              core_rst,
    input  wire              wr,
    input  wire [WIDTH-1:0]  wdata,
    input  wire              rd,
    output logic [WIDTH-1:0] rdata,
    output logic             empty,
    output logic             full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic do_wr;
    logic do_rd;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (count == CW'(DEPTH));
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    // first word fall through, the head is always on rdata
    assign rdata = mem[rd_ptr];

    always_ff @(posedge BUS_CLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge BUS_CLK) disable iff (core_rst) count <= CW'(DEPTH)
    ) else $error("fifo occupancy above depth");

endmodule

`default_nettype wire

//--- hdl/ts_capture.sv
`timescale 1ns/1ps
`default_nettype none

module ts_capture (
    input  wire               BUS_CLK,
    input  wire               core_rst,
    input  wire               di,
    input  wire               enable,
    output ts_pkg::ts_event_t evt
);

    logic di_q;
    logic [63:0] counter;

    // di_q holds the sample of di from the previous edge
    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            di_q <= 1'b0;
        end else begin
            di_q <= di;
        end
    end

    // free-running time base, reads 0 in the first cycle after reset
    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            counter <= '0;
        end else begin
            counter <= counter + 64'd1;
        end
    end

    // the strobe is high in the cycle before the edge that first samples di high,
    // so the event buffer takes it at that same edge
    assign evt.valid = enable && di && !di_q;

    // stamp is the count held just before the sampling edge
    assign evt.stamp = counter;

    // once di has been sampled high, di_q blocks a second strobe
    a_single_strobe: assert property (
        @(posedge BUS_CLK) disable iff (core_rst) evt.valid |=> !evt.valid
    ) else $error("event strobe high on two consecutive cycles");

endmodule

`default_nettype wire

//--- hdl/ts_bus_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ts_bus_regs #(
    parameter int ABUSWIDTH = 16
) (
    input  wire                 BUS_CLK,
    input  wire                 RST_SYNC,
    input  wire [ABUSWIDTH-1:0] bus_add,
    input  wire [7:0]           bus_data_in,
    input  wire                 bus_wr,
    input  wire                 bus_rd,
    input  wire                 evt_valid,
    input  wire                 evt_full,
    output logic [7:0]          bus_data_out,
    output logic                enable,
    output logic                core_rst
);
    import ts_pkg::*;

    logic soft_rst;
    logic evt_drop;
    logic [7:0] lost_cnt;

    // any write to the version address restarts the whole core
    assign soft_rst = bus_wr && (bus_add == ABUSWIDTH'(REG_VERSION));
    assign core_rst = RST_SYNC || soft_rst;

    // an event that meets a full buffer is lost
    assign evt_drop = evt_valid && evt_full;

    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            enable <= 1'b0;
        end else if (bus_wr && (bus_add == ABUSWIDTH'(REG_ENABLE))) begin
            enable <= bus_data_in[0];
        end
    end

    // lost counter sticks at 255 instead of wrapping
    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            lost_cnt <= '0;
        end else if (evt_drop && (lost_cnt != 8'hff)) begin
            lost_cnt <= lost_cnt + 8'd1;
        end
    end

    // read data is held until the next read strobe, soft reset leaves it alone
    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC) begin
            bus_data_out <= '0;
        end else if (bus_rd) begin
            case (bus_add)
                ABUSWIDTH'(REG_VERSION): bus_data_out <= VERSION;
                ABUSWIDTH'(REG_ENABLE): bus_data_out <= {7'b0, enable};
                ABUSWIDTH'(REG_LOST): bus_data_out <= lost_cnt;
                default: bus_data_out <= '0;
            endcase
        end
    end

    a_lost_saturates: assert property (
        @(posedge BUS_CLK) (lost_cnt == 8'hff && !core_rst) |=> (lost_cnt == 8'hff)
    ) else $error("lost counter left 255 without a reset");

endmodule

`default_nettype wire

//--- hdl/ts_pkg.sv
`default_nettype none

package ts_pkg;

    // register map of the byte-wide bus, a write to the version address is the soft reset
    localparam int REG_VERSION = 0;
    localparam int REG_ENABLE = 2;
    localparam int REG_LOST = 3;

    localparam logic [7:0] VERSION = 8'd1;

    // tag in bits 27:24 of every output word, tells which slice of the stamp it carries
    typedef enum logic [3:0] {
        TAG_LOW = 4'd1,
        TAG_MID = 4'd2,
        TAG_HIGH = 4'd3
    } ts_tag_e;

    typedef struct packed {
        logic [3:0] id;
        ts_tag_e tag;
        logic [23:0] payload;
    } ts_word_t;

    typedef struct packed {
        logic valid;
        logic [63:0] stamp;
    } ts_event_t;

    typedef enum logic [1:0] {
        IDLE,
        SEND_LOW,
        SEND_MID,
        SEND_HIGH
    } ts_pack_state_e;

endpackage

`default_nettype wire
